/* hw/stream_stat_pkg.sv */
// Stream statistics block, shared definitions
// Register map, field widths, packet lengths, AXI response codes
// and the reset values used by the control and counter logic

package stream_stat_pkg;

    // ============================================================
    // Widths
    // ============================================================
    // AXI byte address, register index is the word address
    localparam int ADDR_W    = 10;
    localparam int IDX_W     = 8;
    localparam int DATA_W    = 32;
    localparam int CNT_W     = 64;
    // Stream tdata is {port, length}
    localparam int LEN_W     = 16;
    localparam int PORT_W    = 8;
    localparam int NUM_PORTS = 2;

    // ============================================================
    // Packet classes, total length including the 64-byte header
    // ============================================================
    localparam logic [LEN_W-1:0] FD_LENGTH = 16'd4160;
    localparam logic [LEN_W-1:0] MD_LENGTH = 16'd192;
    localparam logic [LEN_W-1:0] FC_LENGTH = 16'd68;

    // Reset values
    localparam logic [PORT_W-1:0]   PORT_RESET     = 8'hFF;
    localparam logic [2*DATA_W-1:0] XMIT_SRC_RESET = 64'h1_0000_0000;

    // AXI response codes, SLVERR is never produced
    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_DECERR = 2'd3;

    // AXI slave FSM states
    localparam logic [1:0] AXI_IDLE    = 2'd0;
    localparam logic [1:0] AXI_WR_RESP = 2'd1;
    localparam logic [1:0] AXI_RD_RESP = 2'd2;

    // ============================================================
    // Register map
    // ============================================================
    // Global registers
    localparam logic [IDX_W-1:0] REG_RESET     = 8'd0;
    localparam logic [IDX_W-1:0] REG_LINK_STAT = 8'd1;

    // One bank per port, same layout in each
    localparam logic [IDX_W-1:0] BANK_BASE_0 = 8'd64;
    localparam logic [IDX_W-1:0] BANK_BASE_1 = 8'd128;

    // Offsets inside a bank, 64-bit values are high word first
    localparam logic [IDX_W-1:0] OFS_PORT       = 8'd0;
    localparam logic [IDX_W-1:0] OFS_XMIT_START = 8'd1;
    localparam logic [IDX_W-1:0] OFS_FD_COUNTH  = 8'd2;
    localparam logic [IDX_W-1:0] OFS_FD_COUNTL  = 8'd3;
    localparam logic [IDX_W-1:0] OFS_MD_COUNTH  = 8'd4;
    localparam logic [IDX_W-1:0] OFS_MD_COUNTL  = 8'd5;
    localparam logic [IDX_W-1:0] OFS_FC_COUNTH  = 8'd6;
    localparam logic [IDX_W-1:0] OFS_FC_COUNTL  = 8'd7;
    localparam logic [IDX_W-1:0] OFS_OTH_COUNTH = 8'd8;
    localparam logic [IDX_W-1:0] OFS_OTH_COUNTL = 8'd9;
    localparam logic [IDX_W-1:0] OFS_BAD_COUNTH = 8'd10;
    localparam logic [IDX_W-1:0] OFS_BAD_COUNTL = 8'd11;
    localparam logic [IDX_W-1:0] OFS_XMIT_SRCH  = 8'd12;
    localparam logic [IDX_W-1:0] OFS_XMIT_SRCL  = 8'd13;

endpackage

/* hw/reg_bus_if.sv */
// Register bus between the AXI4-Lite slave and the register block
// Single-cycle request strobes, response registered by the slave side

`timescale 1ns/1ps

interface reg_bus_if;

    // Write request, wr_en is a one-cycle pulse
    logic                               wr_en;
    logic [stream_stat_pkg::IDX_W-1:0]  wr_idx;
    logic [stream_stat_pkg::DATA_W-1:0] wr_data;
    logic [1:0]                         wr_resp;

    // Read request, data valid the cycle after rd_en
    logic                               rd_en;
    logic [stream_stat_pkg::IDX_W-1:0]  rd_idx;
    logic [stream_stat_pkg::DATA_W-1:0] rd_data;
    logic [1:0]                         rd_resp;

    modport master (output wr_en, wr_idx, wr_data, rd_en, rd_idx,
                    input  wr_resp, rd_data, rd_resp);

    modport slave  (input  wr_en, wr_idx, wr_data, rd_en, rd_idx,
                    output wr_resp, rd_data, rd_resp);

endinterface

/* hw/port_stats_if.sv */
// Per-port statistics from a packet class counter
// All fields are levels and always current

`timescale 1ns/1ps

interface port_stats_if;

    // One 64-bit counter per packet class
    logic [stream_stat_pkg::CNT_W-1:0]  fd_count;
    logic [stream_stat_pkg::CNT_W-1:0]  md_count;
    logic [stream_stat_pkg::CNT_W-1:0]  fc_count;
    logic [stream_stat_pkg::CNT_W-1:0]  oth_count;
    logic [stream_stat_pkg::CNT_W-1:0]  bad_count;

    // Sender port of the last good packet
    logic [stream_stat_pkg::PORT_W-1:0] port_number;

    modport source (output fd_count, md_count, fc_count, oth_count, bad_count,
                    port_number);

    modport sink   (input  fd_count, md_count, fc_count, oth_count, bad_count,
                    port_number);

endinterface

/* hw/axil_slave.sv */
// AXI4-Lite slave for the statistics register file
// One transaction at a time, writes win over reads in the same cycle
// Issues register-bus strobes and holds B/R valid until accepted

`timescale 1ns/1ps

module axil_slave (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic [stream_stat_pkg::ADDR_W-1:0]  awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [stream_stat_pkg::DATA_W-1:0]  wdata,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  logic [stream_stat_pkg::ADDR_W-1:0]  araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [stream_stat_pkg::DATA_W-1:0]  rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready,
    reg_bus_if.master                           bus
);

    logic [1:0] state;

    // Register block holds its response until the next request
    assign bresp = bus.wr_resp;
    assign rresp = bus.rd_resp;
    assign rdata = bus.rd_data;

    // ============================================================
    // Transaction FSM
    // ============================================================
    always_ff @(posedge clk) begin
        // Strobes last one cycle
        bus.wr_en <= 1'b0;
        bus.rd_en <= 1'b0;

        if (!resetn) begin
            state   <= stream_stat_pkg::AXI_IDLE;
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            case (state)
                stream_stat_pkg::AXI_IDLE: begin
                    if (awready) begin
                        // AW and W handshake completes this cycle
                        awready     <= 1'b0;
                        wready      <= 1'b0;
                        bus.wr_en   <= 1'b1;
                        bus.wr_idx  <= awaddr[stream_stat_pkg::ADDR_W-1:2];
                        bus.wr_data <= wdata;
                        state       <= stream_stat_pkg::AXI_WR_RESP;
                    end else if (arready) begin
                        arready    <= 1'b0;
                        bus.rd_en  <= 1'b1;
                        bus.rd_idx <= araddr[stream_stat_pkg::ADDR_W-1:2];
                        state      <= stream_stat_pkg::AXI_RD_RESP;
                    end else if (awvalid && wvalid) begin
                        awready <= 1'b1;
                        wready  <= 1'b1;
                    end else if (arvalid) begin
                        arready <= 1'b1;
                    end
                end

                stream_stat_pkg::AXI_WR_RESP: begin
                    // Response is registered on the wr_en edge
                    if (bus.wr_en) begin
                        bvalid <= 1'b1;
                    end else if (bvalid && bready) begin
                        bvalid <= 1'b0;
                        state  <= stream_stat_pkg::AXI_IDLE;
                    end
                end

                stream_stat_pkg::AXI_RD_RESP: begin
                    if (bus.rd_en) begin
                        rvalid <= 1'b1;
                    end else if (rvalid && rready) begin
                        rvalid <= 1'b0;
                        state  <= stream_stat_pkg::AXI_IDLE;
                    end
                end

                default: state <= stream_stat_pkg::AXI_IDLE;
            endcase
        end
    end

    // Response channels hold valid and payload until the master takes them
    a_b_hold: assert property (@(posedge clk) disable iff (!resetn)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_r_hold: assert property (@(posedge clk) disable iff (!resetn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

/* hw/pkt_class_counter.sv */
// Packet class counter for one length stream
// Sorts each valid beat into frame-data, meta-data, frame-counter,
// other or bad, and tracks the sender port of the last good packet

`timescale 1ns/1ps

module pkt_class_counter (
    input  logic clk,
    input  logic resetn,
    input  logic clear,
    input  logic [stream_stat_pkg::LEN_W+stream_stat_pkg::PORT_W-1:0] tdata,
    input  logic tuser,
    input  logic tvalid,
    port_stats_if.source stats
);

    logic [stream_stat_pkg::LEN_W-1:0]  pkt_len;
    logic [stream_stat_pkg::PORT_W-1:0] pkt_port;
    logic [stream_stat_pkg::CNT_W-1:0]  fd_cnt, md_cnt, fc_cnt, oth_cnt, bad_cnt;
    logic [stream_stat_pkg::CNT_W-1:0]  total;

    // Length in the low half, sender port above it
    assign pkt_len  = tdata[stream_stat_pkg::LEN_W-1:0];
    assign pkt_port = tdata[stream_stat_pkg::LEN_W +: stream_stat_pkg::PORT_W];

    always_ff @(posedge clk) begin
        if (!resetn || clear) begin
            fd_cnt            <= '0;
            md_cnt            <= '0;
            fc_cnt            <= '0;
            oth_cnt           <= '0;
            bad_cnt           <= '0;
            stats.port_number <= stream_stat_pkg::PORT_RESET;
        end else if (tvalid) begin
            // Corrupt flag overrides any length match
            if (tuser)
                bad_cnt <= bad_cnt + 1'b1;
            else if (pkt_len == stream_stat_pkg::FD_LENGTH)
                fd_cnt <= fd_cnt + 1'b1;
            else if (pkt_len == stream_stat_pkg::MD_LENGTH)
                md_cnt <= md_cnt + 1'b1;
            else if (pkt_len == stream_stat_pkg::FC_LENGTH)
                fc_cnt <= fc_cnt + 1'b1;
            else
                oth_cnt <= oth_cnt + 1'b1;

            // Port field of a corrupt packet cannot be trusted
            if (!tuser)
                stats.port_number <= pkt_port;
        end
    end

    assign stats.fd_count  = fd_cnt;
    assign stats.md_count  = md_cnt;
    assign stats.fc_count  = fc_cnt;
    assign stats.oth_count = oth_cnt;
    assign stats.bad_count = bad_cnt;

    // One beat per cycle, so at most one class moves
    assign total = fd_cnt + md_cnt + fc_cnt + oth_cnt + bad_cnt;

    a_one_class: assert property (@(posedge clk) disable iff (!resetn)
        total <= $past(total) + 1);

endmodule

/* hw/ctrl_regs.sv */
// Register block of the statistics core
// Write decode for counter clear and transmit control, read mux for
// link status, per-port counters, port number, source and busy

`timescale 1ns/1ps

module ctrl_regs (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  logic                                  qsfp0_up,
    input  logic                                  qsfp1_up,
    input  logic                                  xmit_idle_0,
    input  logic                                  xmit_idle_1,
    output logic                                  clear,
    output logic [2*stream_stat_pkg::DATA_W-1:0]  xmit_src_0,
    output logic [2*stream_stat_pkg::DATA_W-1:0]  xmit_src_1,
    output logic                                  xmit_start_0,
    output logic                                  xmit_start_1,
    reg_bus_if.slave                              bus,
    port_stats_if.sink                            stats_0,
    port_stats_if.sink                            stats_1
);

    localparam logic [stream_stat_pkg::IDX_W-1:0] BANK_BASE [stream_stat_pkg::NUM_PORTS] =
        '{stream_stat_pkg::BANK_BASE_0, stream_stat_pkg::BANK_BASE_1};

    // Per-port views so both banks share one decode
    logic [stream_stat_pkg::CNT_W-1:0]    fd [stream_stat_pkg::NUM_PORTS];
    logic [stream_stat_pkg::CNT_W-1:0]    md [stream_stat_pkg::NUM_PORTS];
    logic [stream_stat_pkg::CNT_W-1:0]    fc [stream_stat_pkg::NUM_PORTS];
    logic [stream_stat_pkg::CNT_W-1:0]    oth [stream_stat_pkg::NUM_PORTS];
    logic [stream_stat_pkg::CNT_W-1:0]    bad [stream_stat_pkg::NUM_PORTS];
    logic [stream_stat_pkg::PORT_W-1:0]   port_num [stream_stat_pkg::NUM_PORTS];
    logic [2*stream_stat_pkg::DATA_W-1:0] src [stream_stat_pkg::NUM_PORTS];
    logic                                 start [stream_stat_pkg::NUM_PORTS];
    logic                                 busy [stream_stat_pkg::NUM_PORTS];
    logic [stream_stat_pkg::DATA_W-1:0]   rd_word;
    logic                                 rd_hit;

    assign fd[0]       = stats_0.fd_count;
    assign md[0]       = stats_0.md_count;
    assign fc[0]       = stats_0.fc_count;
    assign oth[0]      = stats_0.oth_count;
    assign bad[0]      = stats_0.bad_count;
    assign port_num[0] = stats_0.port_number;
    assign fd[1]       = stats_1.fd_count;
    assign md[1]       = stats_1.md_count;
    assign fc[1]       = stats_1.fc_count;
    assign oth[1]      = stats_1.oth_count;
    assign bad[1]      = stats_1.bad_count;
    assign port_num[1] = stats_1.port_number;

    assign busy[0]      = ~xmit_idle_0;
    assign busy[1]      = ~xmit_idle_1;
    assign xmit_src_0   = src[0];
    assign xmit_src_1   = src[1];
    assign xmit_start_0 = start[0];
    assign xmit_start_1 = start[1];

    // ============================================================
    // Write decode
    // ============================================================
    always_ff @(posedge clk) begin
        // Clear and start are single-cycle pulses
        clear <= 1'b0;
        for (int p = 0; p < stream_stat_pkg::NUM_PORTS; p++)
            start[p] <= 1'b0;

        if (!resetn) begin
            for (int p = 0; p < stream_stat_pkg::NUM_PORTS; p++)
                src[p] <= stream_stat_pkg::XMIT_SRC_RESET;
        end else if (bus.wr_en) begin
            // Later matches override the error
            bus.wr_resp <= stream_stat_pkg::RESP_DECERR;
            if (bus.wr_idx == stream_stat_pkg::REG_RESET) begin
                clear       <= 1'b1;
                bus.wr_resp <= stream_stat_pkg::RESP_OKAY;
            end
            for (int p = 0; p < stream_stat_pkg::NUM_PORTS; p++) begin
                if (bus.wr_idx == BANK_BASE[p] + stream_stat_pkg::OFS_XMIT_START) begin
                    start[p]    <= bus.wr_data[0];
                    bus.wr_resp <= stream_stat_pkg::RESP_OKAY;
                end
                if (bus.wr_idx == BANK_BASE[p] + stream_stat_pkg::OFS_XMIT_SRCH) begin
                    src[p][2*stream_stat_pkg::DATA_W-1:stream_stat_pkg::DATA_W] <= bus.wr_data;
                    bus.wr_resp <= stream_stat_pkg::RESP_OKAY;
                end
                if (bus.wr_idx == BANK_BASE[p] + stream_stat_pkg::OFS_XMIT_SRCL) begin
                    src[p][stream_stat_pkg::DATA_W-1:0] <= bus.wr_data;
                    bus.wr_resp <= stream_stat_pkg::RESP_OKAY;
                end
            end
        end
    end

    // ============================================================
    // Read mux
    // ============================================================
    always_comb begin
        logic [stream_stat_pkg::IDX_W-1:0] ofs;

        rd_word = '0;
        rd_hit  = (bus.rd_idx == stream_stat_pkg::REG_LINK_STAT);
        if (rd_hit)
            rd_word = {{(stream_stat_pkg::DATA_W-2){1'b0}}, qsfp1_up, qsfp0_up};

        for (int p = 0; p < stream_stat_pkg::NUM_PORTS; p++) begin
            ofs = bus.rd_idx - BANK_BASE[p];
            // Bank hit when the index falls inside the 14-word window
            if (bus.rd_idx >= BANK_BASE[p] && ofs <= stream_stat_pkg::OFS_XMIT_SRCL) begin
                rd_hit = 1'b1;
                case (ofs)
                    stream_stat_pkg::OFS_PORT:
                        rd_word = {{(stream_stat_pkg::DATA_W-stream_stat_pkg::PORT_W){1'b0}},
                                   port_num[p]};
                    stream_stat_pkg::OFS_XMIT_START:
                        rd_word = {{(stream_stat_pkg::DATA_W-1){1'b0}}, busy[p]};
                    stream_stat_pkg::OFS_FD_COUNTH:  rd_word = fd[p][63:32];
                    stream_stat_pkg::OFS_FD_COUNTL:  rd_word = fd[p][31:0];
                    stream_stat_pkg::OFS_MD_COUNTH:  rd_word = md[p][63:32];
                    stream_stat_pkg::OFS_MD_COUNTL:  rd_word = md[p][31:0];
                    stream_stat_pkg::OFS_FC_COUNTH:  rd_word = fc[p][63:32];
                    stream_stat_pkg::OFS_FC_COUNTL:  rd_word = fc[p][31:0];
                    stream_stat_pkg::OFS_OTH_COUNTH: rd_word = oth[p][63:32];
                    stream_stat_pkg::OFS_OTH_COUNTL: rd_word = oth[p][31:0];
                    stream_stat_pkg::OFS_BAD_COUNTH: rd_word = bad[p][63:32];
                    stream_stat_pkg::OFS_BAD_COUNTL: rd_word = bad[p][31:0];
                    stream_stat_pkg::OFS_XMIT_SRCH:  rd_word = src[p][63:32];
                    stream_stat_pkg::OFS_XMIT_SRCL:  rd_word = src[p][31:0];
                    default:                         rd_word = '0;
                endcase
            end
        end
    end

    // Read data captured on the rd_en edge and held for the slave
    always_ff @(posedge clk) begin
        if (bus.rd_en) begin
            bus.rd_data <= rd_word;
            bus.rd_resp <= rd_hit ? stream_stat_pkg::RESP_OKAY : stream_stat_pkg::RESP_DECERR;
        end
    end

    // AXI slave serves one request at a time
    a_no_overlap: assert property (@(posedge clk) disable iff (!resetn)
        !(bus.wr_en && bus.rd_en));

endmodule

/* hw/stream_stat_top.sv */
// Dual QSFP packet statistics and transmit control
// AXI4-Lite register access, two length streams, per-port transmit
// source address and start strobe

`timescale 1ns/1ps

module stream_stat_top (
    input  logic                                  clk,
    input  logic                                  resetn,

    // AXI4-Lite slave
    input  logic [stream_stat_pkg::ADDR_W-1:0]    s_axi_awaddr,
    input  logic                                  s_axi_awvalid,
    output logic                                  s_axi_awready,
    input  logic [stream_stat_pkg::DATA_W-1:0]    s_axi_wdata,
    input  logic                                  s_axi_wvalid,
    output logic                                  s_axi_wready,
    output logic [1:0]                            s_axi_bresp,
    output logic                                  s_axi_bvalid,
    input  logic                                  s_axi_bready,
    input  logic [stream_stat_pkg::ADDR_W-1:0]    s_axi_araddr,
    input  logic                                  s_axi_arvalid,
    output logic                                  s_axi_arready,
    output logic [stream_stat_pkg::DATA_W-1:0]    s_axi_rdata,
    output logic [1:0]                            s_axi_rresp,
    output logic                                  s_axi_rvalid,
    input  logic                                  s_axi_rready,

    // Packet length streams, tdata is {port, length}
    input  logic [23:0]                           axis_in0_tdata,
    input  logic                                  axis_in0_tuser,
    input  logic                                  axis_in0_tvalid,
    input  logic [23:0]                           axis_in1_tdata,
    input  logic                                  axis_in1_tuser,
    input  logic                                  axis_in1_tvalid,

    // Link status from the MACs
    input  logic                                  qsfp0_up,
    input  logic                                  qsfp1_up,

    // Transmit control
    output logic [2*stream_stat_pkg::DATA_W-1:0]  xmit_src_0,
    output logic                                  xmit_start_0,
    input  logic                                  xmit_idle_0,
    output logic [2*stream_stat_pkg::DATA_W-1:0]  xmit_src_1,
    output logic                                  xmit_start_1,
    input  logic                                  xmit_idle_1
);

    logic clear;

    reg_bus_if    bus ();
    port_stats_if stats_0 ();
    port_stats_if stats_1 ();

    axil_slave u_axil (
        .clk     (clk),           .resetn  (resetn),
        .awaddr  (s_axi_awaddr),  .awvalid (s_axi_awvalid), .awready (s_axi_awready),
        .wdata   (s_axi_wdata),   .wvalid  (s_axi_wvalid),  .wready  (s_axi_wready),
        .bresp   (s_axi_bresp),   .bvalid  (s_axi_bvalid),  .bready  (s_axi_bready),
        .araddr  (s_axi_araddr),  .arvalid (s_axi_arvalid), .arready (s_axi_arready),
        .rdata   (s_axi_rdata),   .rresp   (s_axi_rresp),   .rvalid  (s_axi_rvalid),
        .rready  (s_axi_rready),  .bus     (bus)
    );

    ctrl_regs u_regs (
        .clk          (clk),          .resetn       (resetn),
        .qsfp0_up     (qsfp0_up),     .qsfp1_up     (qsfp1_up),
        .xmit_idle_0  (xmit_idle_0),  .xmit_idle_1  (xmit_idle_1),
        .clear        (clear),
        .xmit_src_0   (xmit_src_0),   .xmit_src_1   (xmit_src_1),
        .xmit_start_0 (xmit_start_0), .xmit_start_1 (xmit_start_1),
        .bus          (bus),          .stats_0      (stats_0),
        .stats_1      (stats_1)
    );

    // One counter block per stream
    pkt_class_counter u_cnt_0 (
        .clk (clk), .resetn (resetn), .clear (clear),
        .tdata (axis_in0_tdata), .tuser (axis_in0_tuser), .tvalid (axis_in0_tvalid),
        .stats (stats_0)
    );

    pkt_class_counter u_cnt_1 (
        .clk (clk), .resetn (resetn), .clear (clear),
        .tdata (axis_in1_tdata), .tuser (axis_in1_tuser), .tvalid (axis_in1_tvalid),
        .stats (stats_1)
    );

endmodule

/* dv/stream_stat_tb.sv */
// Testbench for the stream statistics block
// Replays the command file against the DUT through AXI4-Lite and the
// two length streams, checking read data, responses and transmit outputs

`timescale 1ns/1ps

module stream_stat_tb;

    localparam real CLK_PERIOD     = 8.0;
    localparam int  CYCLES_PER_CMD = 200;

    logic                                clk;
    logic                                resetn;
    logic [stream_stat_pkg::ADDR_W-1:0]  awaddr;
    logic                                awvalid;
    logic                                awready;
    logic [stream_stat_pkg::DATA_W-1:0]  wdata;
    logic                                wvalid;
    logic                                wready;
    logic [1:0]                          bresp;
    logic                                bvalid;
    logic                                bready;
    logic [stream_stat_pkg::ADDR_W-1:0]  araddr;
    logic                                arvalid;
    logic                                arready;
    logic [stream_stat_pkg::DATA_W-1:0]  rdata;
    logic [1:0]                          rresp;
    logic                                rvalid;
    logic                                rready;
    logic [23:0]                         tdata [2];
    logic                                tuser [2];
    logic                                tvalid [2];
    logic                                qsfp0_up;
    logic                                qsfp1_up;
    logic                                xmit_idle [2];
    logic [63:0]                         xmit_src_0;
    logic [63:0]                         xmit_src_1;
    logic                                xmit_start_0;
    logic                                xmit_start_1;

    // Command file contents with one entry per command line
    logic [7:0]  cmd_q [$];
    logic [63:0] arg1_q [$];
    logic [63:0] arg2_q [$];
    logic [63:0] arg3_q [$];
    logic [63:0] arg4_q [$];
    logic        loaded = 1'b0;
    int          start_pulses [2] = '{0, 0};

    stream_stat_top u_dut (
        .clk             (clk),          .resetn          (resetn),
        .s_axi_awaddr    (awaddr),       .s_axi_awvalid   (awvalid),
        .s_axi_awready   (awready),      .s_axi_wdata     (wdata),
        .s_axi_wvalid    (wvalid),       .s_axi_wready    (wready),
        .s_axi_bresp     (bresp),        .s_axi_bvalid    (bvalid),
        .s_axi_bready    (bready),       .s_axi_araddr    (araddr),
        .s_axi_arvalid   (arvalid),      .s_axi_arready   (arready),
        .s_axi_rdata     (rdata),        .s_axi_rresp     (rresp),
        .s_axi_rvalid    (rvalid),       .s_axi_rready    (rready),
        .axis_in0_tdata  (tdata[0]),     .axis_in0_tuser  (tuser[0]),
        .axis_in0_tvalid (tvalid[0]),    .axis_in1_tdata  (tdata[1]),
        .axis_in1_tuser  (tuser[1]),     .axis_in1_tvalid (tvalid[1]),
        .qsfp0_up        (qsfp0_up),     .qsfp1_up        (qsfp1_up),
        .xmit_src_0      (xmit_src_0),   .xmit_start_0    (xmit_start_0),
        .xmit_idle_0     (xmit_idle[0]), .xmit_src_1      (xmit_src_1),
        .xmit_start_1    (xmit_start_1), .xmit_idle_1     (xmit_idle[1])
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Start pulses counted mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (xmit_start_0)
            start_pulses[0]++;
        if (xmit_start_1)
            start_pulses[1]++;
    end

    // ============================================================
    // Helpers
    // ============================================================
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected)
            abort_run($sformatf("Error at time %0t: %s is 0x%0h, expected 0x%0h",
                                $time, what, actual, expected));
    endtask

    // Outputs are read right after the edge, before the DUT updates them
    task automatic axi_write(input logic [7:0] idx, input logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        awaddr  <= {idx, 2'b00};
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        @(posedge clk);
        while (!awready)
            @(posedge clk);
        // AW and W are accepted together
        check($sformatf("write 0x%02h wready", idx), wready, 1'b1);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(posedge clk);
        while (!bvalid)
            @(posedge clk);
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] idx, output logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge clk);
        araddr  <= {idx, 2'b00};
        arvalid <= 1'b1;
        rready  <= 1'b1;
        @(posedge clk);
        while (!arready)
            @(posedge clk);
        arvalid <= 1'b0;
        @(posedge clk);
        while (!rvalid)
            @(posedge clk);
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    // One beat with tdata as {sender, length}
    task automatic send_beat(input logic port, input logic [15:0] len,
                             input logic [7:0] sender, input logic bad);
        @(posedge clk);
        tdata[port]  <= {sender, len};
        tuser[port]  <= bad;
        tvalid[port] <= 1'b1;
        @(posedge clk);
        tvalid[port] <= 1'b0;
    endtask

    // ============================================================
    // Watchdog
    // ============================================================
    initial begin
        wait (loaded);
        #((cmd_q.size() + 1) * CYCLES_PER_CMD * CLK_PERIOD);
        abort_run("Test timed out before all commands finished");
    end

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        int          fd;
        int          ch;
        int          got;
        logic [7:0]  c;
        logic [63:0] f1, f2, f3, f4;
        logic [31:0] data;
        logic [1:0]  resp;

        resetn    = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        qsfp0_up  = 1'b1;
        qsfp1_up  = 1'b0;
        for (int p = 0; p < 2; p++) begin
            tdata[p]     = '0;
            tuser[p]     = 1'b0;
            tvalid[p]    = 1'b0;
            xmit_idle[p] = 1'b1;
        end

        fd = $fopen("dv/stream_stat_input.txt", "r");
        if (fd == 0)
            abort_run("Cannot open the command file dv/stream_stat_input.txt");
        // Field count depends on the command letter
        while ($fscanf(fd, " %c", c) == 1) begin
            if (c == "#") begin
                ch = $fgetc(fd);
                while (ch != "\n" && ch != -1)
                    ch = $fgetc(fd);
            end else begin
                f4 = '0;
                if (c == "b")
                    got = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                else if (c == "i")
                    got = $fscanf(fd, "%h %h", f1, f2) + 2;
                else
                    got = $fscanf(fd, "%h %h %h", f1, f2, f3) + 1;
                if (got != 4)
                    abort_run($sformatf("Malformed '%c' line in the command file", c));
                cmd_q.push_back(c);
                arg1_q.push_back(f1);
                arg2_q.push_back(f2);
                arg3_q.push_back(f3);
                arg4_q.push_back(f4);
            end
        end
        $fclose(fd);
        loaded = 1'b1;

        repeat (4) @(posedge clk);
        resetn <= 1'b1;

        for (int i = 0; i < cmd_q.size(); i++) begin
            f1 = arg1_q[i];
            f2 = arg2_q[i];
            f3 = arg3_q[i];
            f4 = arg4_q[i];
            case (cmd_q[i])
                "b": send_beat(f1[0], f2[15:0], f3[7:0], f4[0]);
                "w": begin
                    axi_write(f1[7:0], f2[31:0], resp);
                    check($sformatf("write 0x%02h response", f1[7:0]), resp, f3);
                end
                "r": begin
                    axi_read(f1[7:0], data, resp);
                    check($sformatf("read 0x%02h response", f1[7:0]), resp, f3);
                    check($sformatf("read 0x%02h data", f1[7:0]), data, f2);
                end
                "i": begin
                    @(posedge clk);
                    xmit_idle[f1[0]] <= f2[0];
                end
                "x": begin
                    check($sformatf("xmit_src of port %0d", f1[0]),
                          f1[0] ? xmit_src_1 : xmit_src_0, f2);
                    check($sformatf("xmit_start pulses of port %0d", f1[0]),
                          start_pulses[f1[0]], f3);
                end
                default: abort_run($sformatf("Unknown command '%c' in the command file",
                                             cmd_q[i]));
            endcase
        end

        repeat (2) @(posedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

/* dv/stream_stat_input.txt */
# Stream statistics commands, every field in hex
# b port length sender bad | w index data resp | r index data resp
# i port idle | x port xmit_src start_pulses
# Reset values, qsfp0 up and qsfp1 down
r 01 00000001 0
r 43 00000000 0
r 8b 00000000 0
r 40 000000ff 0
r 4c 00000001 0
r 41 00000000 0
x 0 0000000100000000 0
# One beat of each class on port 0, the corrupt one has a frame-counter length
b 0 1040 05 0
b 0 00c0 05 0
b 0 0044 06 0
b 0 0100 07 0
b 0 0044 09 1
r 43 00000001 0
r 45 00000001 0
r 47 00000001 0
r 49 00000001 0
r 4b 00000001 0
r 40 00000007 0
r 83 00000000 0
# Port 1, the corrupt beat keeps the sender of the good one
b 1 1040 0c 0
b 1 0999 0d 1
r 83 00000001 0
r 8b 00000001 0
r 80 0000000c 0
# Clear both ports
w 00 00000001 0
r 43 00000000 0
r 8b 00000000 0
r 40 000000ff 0
r 80 000000ff 0
# Transmit source and start
w 8c 12345678 0
w 8d 9abcdef0 0
r 8c 12345678 0
x 1 123456789abcdef0 0
w 41 00000001 0
x 0 0000000100000000 1
x 1 123456789abcdef0 0
i 1 0
r 81 00000001 0
r 41 00000000 0
# Decode errors
r 02 00000000 3
w 02 00000001 3
r c8 00000000 3
w c8 00000001 3
w 43 00000005 3
r 43 00000000 0

/* src.f */
hw/stream_stat_pkg.sv
hw/reg_bus_if.sv
hw/port_stats_if.sv
hw/axil_slave.sv
hw/pkt_class_counter.sv
hw/ctrl_regs.sv
hw/stream_stat_top.sv
dv/stream_stat_tb.sv

/* Bender.yml */
package:
  name: stream_stat

sources:
  - hw/stream_stat_pkg.sv
  - hw/reg_bus_if.sv
  - hw/port_stats_if.sv
  - hw/axil_slave.sv
  - hw/pkt_class_counter.sv
  - hw/ctrl_regs.sv
  - hw/stream_stat_top.sv
  - target: test
    files:
      - dv/stream_stat_tb.sv
